//--- source/lease_pkg.sv
/* shared widths and bus structs for the lease replacement engine
   a lease of zero marks a line as expired */
package lease_pkg;

	// ------------------------------
	// widths
	localparam int LEASE_BW    = 16;	// one lease value
	localparam int REF_ADDR_BW = 30;	// word address of the referencing instruction
	localparam int PROB_BW     = 9;		// matches the 9b lfsr range
	localparam int WB_DATA_BW  = 32;	// wishbone data bus

	typedef logic [LEASE_BW-1:0]    lease_t;
	typedef logic [REF_ADDR_BW-1:0] ref_addr_t;
	typedef logic [PROB_BW-1:0]     prob_t;

	// ------------------------------
	// lookup table search result, 42 bits
	typedef struct packed {
		logic   match;		// search address found in a valid entry
		lease_t lease0;
		lease_t lease1;
		prob_t  lease0_prob;	// likelihood of lease0 out of 511
	} llt_result_t;

	// one table write, index travels beside it
	typedef struct packed {
		logic                  wren;
		logic [1:0]            table_sel;	// 0 ref addr, 1 lease0, 2 lease1, 3 prob
		logic [WB_DATA_BW-1:0] data;
	} llt_write_t;

	typedef enum logic {
		ST_NORMAL,
		ST_GEN_REPLACEMENT
	} policy_state_t;

	// controller response, line address carried separately
	typedef struct packed {
		logic done;		// replacement finished, held until next miss
		logic swap;		// missed line is to be allocated
		logic expired;	// victim was an expired way
		logic dflt;		// default lease was used
	} policy_resp_t;

endpackage

//--- source/lfsr_9b.sv
/* 9 bit fibonacci lfsr, taps 9 and 5, 511 state sequence
   SEED must be non-zero or the register locks at zero */
module lfsr_9b #(
	parameter lease_pkg::prob_t SEED = 9'h001
) (
	input  logic             clock_i,
	input  logic             resetn_i,
	input  logic             enable_i,	// one step per enabled cycle
	output lease_pkg::prob_t value_o
);
	import lease_pkg::*;

	prob_t state_q;
	logic  feedback;

	assign feedback = state_q[8] ^ state_q[4];	// x^9 + x^5 + 1
	assign value_o  = state_q;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q <= SEED;
		end else if (enable_i) begin
			state_q <= {state_q[7:0], feedback};	// shift toward msb
		end
	end

endmodule

//--- source/lease_lookup_table.sv
/* programmable lease table with combinational search, lowest matching index wins
   entries can only be overwritten, never removed */
module lease_lookup_table #(
	parameter int LLT_ENTRIES = 8
) (
	input  logic                           clock_i,
	input  logic                           resetn_i,
	input  lease_pkg::llt_write_t          write_i,
	input  logic [$clog2(LLT_ENTRIES)-1:0] index_i,
	input  lease_pkg::ref_addr_t           search_addr_i,
	output lease_pkg::llt_result_t         result_o
);
	import lease_pkg::*;

	// ------------------------------
	// storage
	ref_addr_t        ref_addr_q [LLT_ENTRIES];
	lease_t           lease0_q   [LLT_ENTRIES];
	lease_t           lease1_q   [LLT_ENTRIES];
	prob_t            prob_q     [LLT_ENTRIES];
	logic [LLT_ENTRIES-1:0] valid_q;	// set once the ref addr is written

	// valid bits are the only control state here
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
		end else if (write_i.wren && write_i.table_sel == 2'd0) begin
			valid_q[index_i] <= 1'b1;
		end
	end

	// field writes, data narrowed to each table width
	always_ff @(posedge clock_i) begin
		if (write_i.wren) begin
			case (write_i.table_sel)
				2'd0: ref_addr_q[index_i] <= write_i.data[REF_ADDR_BW-1:0];
				2'd1: lease0_q[index_i]   <= write_i.data[LEASE_BW-1:0];
				2'd2: lease1_q[index_i]   <= write_i.data[LEASE_BW-1:0];
				default: prob_q[index_i]  <= write_i.data[PROB_BW-1:0];
			endcase
		end
	end

	// ------------------------------
	// parallel compare
	logic [LLT_ENTRIES-1:0] hit_vec;

	always_comb begin
		for (int i = 0; i < LLT_ENTRIES; i++) begin
			hit_vec[i] = valid_q[i] && (ref_addr_q[i] == search_addr_i);
		end
	end

	// first-match reduction, walk down so index 0 has the last word
	always_comb begin
		result_o = '0;
		for (int i = LLT_ENTRIES - 1; i >= 0; i--) begin
			if (hit_vec[i]) begin
				result_o.match       = 1'b1;
				result_o.lease0      = lease0_q[i];
				result_o.lease1      = lease1_q[i];
				result_o.lease0_prob = prob_q[i];
			end
		end
	end

endmodule

//--- source/lease_probability_select.sv
/* picks lease0 with probability lease0_prob/511, lease1 otherwise
   prob 511 always gives lease0, prob 0 always gives lease1 */
module lease_probability_select (
	input  logic                   clock_i,
	input  logic                   resetn_i,
	input  logic                   step_i,		// advance random value after each access
	input  lease_pkg::llt_result_t lookup_i,
	output lease_pkg::lease_t      lease_o
);
	import lease_pkg::*;

	prob_t rand_val;	// 1..511, never zero

	lfsr_9b #(
		.SEED     (9'h0d3)	// differs from the controller's backup lfsr
	) lfsr_9b_inst (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.enable_i (step_i),
		.value_o  (rand_val)
	);

	// a draw at or below the stored likelihood takes lease0
	assign lease_o = (rand_val <= lookup_i.lease0_prob) ? lookup_i.lease0 : lookup_i.lease1;

endmodule

//--- source/lease_config_wb_slave.sv
/* wishbone classic slave, one wait state, ack held for a single cycle
   reads return only the default lease at config word 0, all else reads zero */
module lease_config_wb_slave #(
	parameter int LLT_ENTRIES = 8
) (
	input  logic                                clock_i,
	input  logic                                resetn_i,
	input  logic                                wb_cyc_i,
	input  logic                                wb_stb_i,
	input  logic                                wb_we_i,
	input  logic [$clog2(LLT_ENTRIES)+2:0]      wb_adr_i,	// {cfg, table_sel, index}
	input  logic [lease_pkg::WB_DATA_BW-1:0]    wb_dat_i,
	output logic [lease_pkg::WB_DATA_BW-1:0]    wb_dat_o,
	output logic                                wb_ack_o,
	output lease_pkg::llt_write_t               llt_write_o,
	output logic [$clog2(LLT_ENTRIES)-1:0]      llt_index_o,
	output lease_pkg::lease_t                   default_lease_o
);
	import lease_pkg::*;

	localparam int IDX_BW = $clog2(LLT_ENTRIES);

	logic                  req;
	logic                  cfg_space;	// top address bit
	logic                  cfg_word0;
	logic                  wren_q;
	logic [1:0]            sel_q;
	logic [WB_DATA_BW-1:0] data_q;

	assign req       = wb_cyc_i & wb_stb_i & ~wb_ack_o;	// no new request in the ack cycle
	assign cfg_space = wb_adr_i[IDX_BW+2];
	assign cfg_word0 = cfg_space && (wb_adr_i[IDX_BW+1:0] == '0);

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			wb_ack_o        <= 1'b0;
			wren_q          <= 1'b0;
			default_lease_o <= '0;
		end else begin
			wb_ack_o <= req;
			wren_q   <= req & wb_we_i & ~cfg_space;	// table write lines up with ack
			if (req && wb_we_i && cfg_word0) begin
				default_lease_o <= wb_dat_i[LEASE_BW-1:0];
			end
		end
	end

	// payload captured with the request
	always_ff @(posedge clock_i) begin
		if (req) begin
			sel_q       <= wb_adr_i[IDX_BW+1:IDX_BW];
			llt_index_o <= wb_adr_i[IDX_BW-1:0];
			data_q      <= wb_dat_i;
			wb_dat_o    <= cfg_word0 ? {{(WB_DATA_BW-LEASE_BW){1'b0}}, default_lease_o} : '0;
		end
	end

	assign llt_write_o = '{wren: wren_q, table_sel: sel_q, data: data_q};

endmodule

//--- source/lease_policy_controller.sv
/* lease per line, low line bits are the set, high bits the way; needs at least 2 sets
   no back-pressure, strobes during replacement are dropped, caller waits for done */
module lease_policy_controller #(
	parameter int CACHE_BLOCK_CAPACITY = 16,
	parameter int CACHE_SET_SIZE       = 4
) (
	input  logic                                    clock_i,
	input  logic                                    resetn_i,
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] cache_addr_i,
	input  logic                                    hit_i,
	input  logic                                    miss_i,
	input  logic                                    lookup_match_i,
	input  lease_pkg::lease_t                       lease_i,		// selected table lease
	input  lease_pkg::lease_t                       default_lease_i,
	output logic                                    step_o,		// advance probability lfsr
	output lease_pkg::policy_resp_t                 resp_o,
	output logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] addr_o
);
	import lease_pkg::*;

	localparam int BW_LINE = $clog2(CACHE_BLOCK_CAPACITY);
	localparam int BW_WAY  = $clog2(CACHE_SET_SIZE);
	localparam int BW_SET  = BW_LINE - BW_WAY;
	localparam int N_SETS  = CACHE_BLOCK_CAPACITY / CACHE_SET_SIZE;

	typedef logic [BW_LINE-1:0] line_t;
	typedef logic [BW_WAY-1:0]  way_t;
	typedef logic [BW_SET-1:0]  set_t;

	// lowest set flag wins
	function automatic way_t lowest_way(input logic [CACHE_SET_SIZE-1:0] flags);
		way_t w;
		w = '0;
		for (int i = CACHE_SET_SIZE - 1; i >= 0; i--) begin
			if (flags[i]) w = way_t'(i);
		end
		return w;
	endfunction

	// ------------------------------
	// state
	policy_state_t state_q;
	policy_resp_t  resp_q;
	line_t         addr_q;
	lease_t        lease_q [CACHE_BLOCK_CAPACITY];	// one per line
	way_t          cold_cnt_q [N_SETS];				// next cold-start way
	logic [N_SETS-1:0] full_q;						// set filled since reset
	lease_t        lease_saved_q;					// lease for the follow-up fill
	set_t          miss_set_q;
	logic          followup_q;
	logic          step_q;
	logic          rand_en_q;
	lease_t        chosen_lease;
	prob_t         rand_val;
	way_t          rand_way;
	logic [CACHE_SET_SIZE-1:0] set_expired [N_SETS];
	way_t          exp_way [N_SETS];

	assign chosen_lease = lookup_match_i ? lease_i : default_lease_i;
	assign rand_way     = rand_val[BW_WAY:1];
	assign step_o       = step_q;
	assign resp_o       = resp_q;
	assign addr_o       = addr_q;

	// expired flags regrouped per set, then encoded
	always_comb begin
		for (int s = 0; s < N_SETS; s++) begin
			for (int w = 0; w < CACHE_SET_SIZE; w++) begin
				set_expired[s][w] = (lease_q[w * N_SETS + s] == '0);
			end
			exp_way[s] = lowest_way(set_expired[s]);
		end
	end

	// backup way when nothing in the set has expired
	lfsr_9b #(
		.SEED     (9'h155)
	) lfsr_9b_inst (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.enable_i (rand_en_q),
		.value_o  (rand_val)
	);

	// ------------------------------
	// payload, victim address
	always_ff @(posedge clock_i) begin
		if (state_q == ST_NORMAL && miss_i) begin
			lease_saved_q <= chosen_lease;
			miss_set_q    <= cache_addr_i[BW_SET-1:0];	// set held through replacement
		end
		if (state_q == ST_GEN_REPLACEMENT) begin
			if (!full_q[miss_set_q])                  addr_q <= {cold_cnt_q[miss_set_q], miss_set_q};
			else if (|set_expired[miss_set_q])        addr_q <= {exp_way[miss_set_q], miss_set_q};
			else                                      addr_q <= {rand_way, miss_set_q};
		end
	end

	// ------------------------------
	// replacement fsm
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q    <= ST_NORMAL;
			resp_q     <= '0;
			full_q     <= '0;
			followup_q <= 1'b0;
			step_q     <= 1'b0;
			rand_en_q  <= 1'b0;
			for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++) lease_q[i] <= '0;
			for (int s = 0; s < N_SETS; s++) cold_cnt_q[s] <= '0;
		end else begin
			step_q         <= 1'b0;	// pulses
			rand_en_q      <= 1'b0;
			resp_q.expired <= 1'b0;
			resp_q.dflt    <= 1'b0;
			case (state_q)
				ST_NORMAL: begin
					if (hit_i) begin
						step_q <= 1'b1;
						if (followup_q) begin	// fill after allocating miss, already decremented
							followup_q            <= 1'b0;
							lease_q[cache_addr_i] <= lease_saved_q;
						end else begin
							for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++) begin
								if (lease_q[i] != '0) lease_q[i] <= lease_q[i] - 1'b1;
							end
							lease_q[cache_addr_i] <= chosen_lease;	// renew overrides decrement
							resp_q.dflt           <= ~lookup_match_i;
						end
					end else if (miss_i) begin
						step_q <= 1'b1;
						for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++) begin
							if (lease_q[i] != '0) lease_q[i] <= lease_q[i] - 1'b1;
						end
						if (chosen_lease == '0) begin	// bypass, nothing allocated
							resp_q.done <= 1'b1;
							resp_q.swap <= 1'b0;
							resp_q.dflt <= ~lookup_match_i;
						end else begin
							resp_q.done <= 1'b0;
							resp_q.swap <= 1'b1;
							followup_q  <= 1'b1;
							state_q     <= ST_GEN_REPLACEMENT;
						end
					end
				end
				ST_GEN_REPLACEMENT: begin
					resp_q.done <= 1'b1;
					state_q     <= ST_NORMAL;
					if (!full_q[miss_set_q]) begin
						// cold start walks ways 0..N-1
						cold_cnt_q[miss_set_q] <= cold_cnt_q[miss_set_q] + 1'b1;
						if (cold_cnt_q[miss_set_q] == '1) full_q[miss_set_q] <= 1'b1;
					end else if (|set_expired[miss_set_q]) begin
						resp_q.expired <= 1'b1;
					end else begin
						rand_en_q <= 1'b1;	// consume the random way
					end
				end
				default: state_q <= ST_NORMAL;
			endcase
		end
	end

endmodule

//--- source/lease_cache_top.sv
/* lease replacement engine, wishbone config port plus strobe access port
   cache_addr_i and search_addr_i must be valid with each hit or miss strobe */
module lease_cache_top #(
	parameter int CACHE_BLOCK_CAPACITY = 16,	// power of two
	parameter int CACHE_SET_SIZE       = 4,		// 2, 4 or 8 ways
	parameter int LLT_ENTRIES          = 8		// power of two
) (
	input  logic                                    clock_i,
	input  logic                                    resetn_i,
	input  logic                                    wb_cyc_i,
	input  logic                                    wb_stb_i,
	input  logic                                    wb_we_i,
	input  logic [$clog2(LLT_ENTRIES)+2:0]          wb_adr_i,
	input  logic [lease_pkg::WB_DATA_BW-1:0]        wb_dat_i,
	output logic [lease_pkg::WB_DATA_BW-1:0]        wb_dat_o,
	output logic                                    wb_ack_o,
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] cache_addr_i,
	input  lease_pkg::ref_addr_t                    search_addr_i,
	input  logic                                    hit_i,
	input  logic                                    miss_i,
	output lease_pkg::policy_resp_t                 resp_o,
	output logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] addr_o
);
	import lease_pkg::*;

	llt_write_t                     llt_write;
	logic [$clog2(LLT_ENTRIES)-1:0] llt_index;
	lease_t                         default_lease;
	llt_result_t                    llt_result;
	lease_t                         sel_lease;
	logic                           step;

	// ------------------------------
	lease_config_wb_slave #(
		.LLT_ENTRIES     (LLT_ENTRIES)
	) lease_config_wb_slave_inst (
		.clock_i         (clock_i),
		.resetn_i        (resetn_i),
		.wb_cyc_i        (wb_cyc_i),
		.wb_stb_i        (wb_stb_i),
		.wb_we_i         (wb_we_i),
		.wb_adr_i        (wb_adr_i),
		.wb_dat_i        (wb_dat_i),
		.wb_dat_o        (wb_dat_o),
		.wb_ack_o        (wb_ack_o),
		.llt_write_o     (llt_write),
		.llt_index_o     (llt_index),
		.default_lease_o (default_lease)
	);

	lease_lookup_table #(
		.LLT_ENTRIES   (LLT_ENTRIES)
	) lease_lookup_table_inst (
		.clock_i       (clock_i),
		.resetn_i      (resetn_i),
		.write_i       (llt_write),
		.index_i       (llt_index),
		.search_addr_i (search_addr_i),
		.result_o      (llt_result)
	);

	lease_probability_select lease_probability_select_inst (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.step_i   (step),
		.lookup_i (llt_result),
		.lease_o  (sel_lease)
	);

	// ------------------------------
	lease_policy_controller #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY),
		.CACHE_SET_SIZE       (CACHE_SET_SIZE)
	) lease_policy_controller_inst (
		.clock_i         (clock_i),
		.resetn_i        (resetn_i),
		.cache_addr_i    (cache_addr_i),
		.hit_i           (hit_i),
		.miss_i          (miss_i),
		.lookup_match_i  (llt_result.match),
		.lease_i         (sel_lease),
		.default_lease_i (default_lease),
		.step_o          (step),
		.resp_o          (resp_o),
		.addr_o          (addr_o)
	);

endmodule

//--- testbench/lease_cache_asserts.sv
/* concurrent checks on the access strobes, the replacement response and the wishbone ack
   bound into the top level where both ports meet, idle while reset is low */
module lease_cache_asserts (
	input logic                    clock_i,
	input logic                    resetn_i,
	input logic                    hit_i,
	input logic                    miss_i,
	input lease_pkg::policy_resp_t resp_i,
	input logic                    wb_ack_i
);

	// cache controller never raises both strobes
	strobe_exclusive: assert property (@(posedge clock_i) disable iff (!resetn_i)
		!(hit_i && miss_i))
		else $error("hit and miss strobes high in the same cycle");

	expired_with_done: assert property (@(posedge clock_i) disable iff (!resetn_i)
		resp_i.expired |-> resp_i.done)	// victim flag only with a finished replacement
		else $error("expired pulsed while done was low");

	ack_single_cycle: assert property (@(posedge clock_i) disable iff (!resetn_i)
		wb_ack_i |=> !wb_ack_i)
		else $error("wishbone ack held for more than one cycle");

endmodule

// ------------------------------
bind lease_cache_top lease_cache_asserts lease_cache_asserts_inst (
	.clock_i  (clock_i),
	.resetn_i (resetn_i),
	.hit_i    (hit_i),
	.miss_i   (miss_i),
	.resp_i   (resp_o),
	.wb_ack_i (wb_ack_o)
);

//--- testbench/lease_cache_tb.sv
/* directed tests for the lease engine at 16 lines, 4 ways, 8 table entries
   expected responses come from a lease model, table probabilities limited to 0 and 511 */
module lease_cache_tb;
	import lease_pkg::*;

	localparam int LINES       = 16;
	localparam int WAYS        = 4;
	localparam int SETS        = LINES / WAYS;
	localparam int SET_BW      = $clog2(SETS);
	localparam int ENTRIES     = 8;
	localparam int CLK_PERIOD  = 20;
	localparam int TEST_CYCLES = 300;	// upper bound over all tests
	localparam int FILL_LINE   = 3;		// way 0 of set 3, used to age other lines
	localparam logic [5:0] ADR_DEFAULT = 6'h20;	// config word 0
	localparam ref_addr_t  ADDR_A      = 30'h0000_1a40;
	localparam ref_addr_t  ADDR_B      = 30'h0000_2b80;

	logic         clock = 1'b0;
	logic         resetn;
	logic         wb_cyc;
	logic         wb_stb;
	logic         wb_we;
	logic [5:0]   wb_adr;
	logic [31:0]  wb_dat;
	logic [31:0]  wb_dat_o;
	logic         wb_ack;
	logic [3:0]   cache_addr;
	ref_addr_t    search_addr;
	logic         hit;
	logic         miss;
	policy_resp_t resp;
	logic [3:0]   line_addr;

	// ------------------------------
	// reference model state
	lease_t      m_lease [LINES];
	int          m_cold [SETS];		// next cold-start way
	logic        m_full [SETS];
	lease_t      m_default;
	lease_t      m_saved;			// lease for the follow-up fill
	logic        m_followup;
	logic        m_done;
	ref_addr_t   t_addr [ENTRIES];
	lease_t      t_lease0 [ENTRIES];
	lease_t      t_lease1 [ENTRIES];
	prob_t       t_prob [ENTRIES];
	logic        t_valid [ENTRIES];
	int          errors;
	logic [31:0] rng_state;

	always #(CLK_PERIOD / 2) clock = ~clock;

	lease_cache_top #(
		.CACHE_BLOCK_CAPACITY (LINES),
		.CACHE_SET_SIZE       (WAYS),
		.LLT_ENTRIES          (ENTRIES)
	) lease_cache_top_inst (
		.clock_i       (clock),
		.resetn_i      (resetn),
		.wb_cyc_i      (wb_cyc),
		.wb_stb_i      (wb_stb),
		.wb_we_i       (wb_we),
		.wb_adr_i      (wb_adr),
		.wb_dat_i      (wb_dat),
		.wb_dat_o      (wb_dat_o),
		.wb_ack_o      (wb_ack),
		.cache_addr_i  (cache_addr),
		.search_addr_i (search_addr),
		.hit_i         (hit),
		.miss_i        (miss),
		.resp_o        (resp),
		.addr_o        (line_addr)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic ref_addr_t random_ref_addr();
		rng_state = xorshift32(rng_state);
		return {1'b1, rng_state[28:0]};	// top bit set, never a table address
	endfunction

	// lease a hit or miss would pick, first valid entry wins
	function automatic lease_t model_lease_for(input ref_addr_t a, output logic match);
		lease_t l;
		match = 1'b0;
		l = m_default;
		for (int i = ENTRIES - 1; i >= 0; i--) begin
			if (t_valid[i] && t_addr[i] == a) begin
				match = 1'b1;
				l = (t_prob[i] == 9'd511) ? t_lease0[i] : t_lease1[i];	// 0 picks lease1
			end
		end
		return l;
	endfunction

	function automatic void model_decrement();
		for (int i = 0; i < LINES; i++) begin
			if (m_lease[i] != '0) begin
				m_lease[i] = m_lease[i] - 16'd1;
			end
		end
	endfunction

	function automatic logic set_run_down(input int set);
		logic down;
		down = 1'b1;
		for (int w = 0; w < WAYS; w++) begin
			if (m_lease[w * SETS + set] > 16'd1) down = 1'b0;
		end
		return down;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("Error: %s = %h, expected %h at %0t", name, got, exp, $time);
		errors++;
	endtask

	task automatic report_failure(input string msg);
		$display("%s at %0t", msg, $time);
		errors++;
	endtask

	// ------------------------------
	// wishbone master, entered and left on a falling edge
	task automatic wb_transfer(input logic we, input logic [5:0] adr, input logic [31:0] wdat,
			output logic [31:0] rdat);
		int cycles;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = we;
		wb_adr = adr;
		wb_dat = wdat;
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
		end while (wb_ack !== 1'b1 && cycles < 8);
		rdat = wb_dat_o;
		if (wb_ack !== 1'b1) report_failure("Wishbone ack never came");
		else if (cycles != 1) report_failure("Wishbone ack came later than one cycle");
		wb_cyc = 1'b0;
		wb_stb = 1'b0;	// drop strobe after the ack
		wb_we  = 1'b0;
		@(negedge clock);
		if (wb_ack !== 1'b0) report_failure("Wishbone ack lasted more than one cycle");
	endtask

	task automatic wb_write(input logic [5:0] adr, input logic [31:0] data);
		logic [31:0] unused;
		wb_transfer(1'b1, adr, data, unused);
		if (adr == ADR_DEFAULT) m_default = data[15:0];
	endtask

	task automatic write_table_entry(input int idx, input ref_addr_t a, input lease_t l0,
			input lease_t l1, input prob_t p);
		wb_write({1'b0, 2'd0, 3'(idx)}, 32'(a));	// ref addr, sets valid
		wb_write({1'b0, 2'd1, 3'(idx)}, 32'(l0));
		wb_write({1'b0, 2'd2, 3'(idx)}, 32'(l1));
		wb_write({1'b0, 2'd3, 3'(idx)}, 32'(p));
		t_addr[idx]   = a;
		t_lease0[idx] = l0;
		t_lease1[idx] = l1;
		t_prob[idx]   = p;
		t_valid[idx]  = 1'b1;
	endtask

	// ------------------------------
	// access port
	task automatic do_hit(input int line, input ref_addr_t saddr);
		logic   match;
		logic   exp_dflt;
		lease_t l;
		l = model_lease_for(saddr, match);
		cache_addr  = 4'(line);
		search_addr = saddr;
		hit         = 1'b1;
		@(negedge clock);
		hit = 1'b0;
		if (m_followup) begin	// fill after an allocating miss, no aging
			m_followup    = 1'b0;
			m_lease[line] = m_saved;
			exp_dflt      = 1'b0;
		end else begin
			model_decrement();
			m_lease[line] = l;
			exp_dflt      = ~match;
		end
		if (resp.dflt !== exp_dflt) report_mismatch("resp_o.dflt", resp.dflt, exp_dflt);
		if (resp.done !== m_done) report_mismatch("resp_o.done", resp.done, m_done);
	endtask

	// victim is -1 when the miss bypasses
	task automatic do_miss(input int set, input ref_addr_t saddr, output int victim);
		logic   match;
		logic   exp_dflt;
		logic   exp_expired;
		lease_t l;
		int     cycles;
		int     way;
		l = model_lease_for(saddr, match);
		exp_dflt    = ~match;
		victim      = -1;
		cache_addr  = 4'(set);
		search_addr = saddr;
		miss        = 1'b1;
		@(negedge clock);
		miss = 1'b0;
		model_decrement();
		if (l == '0) begin
			if (resp.done !== 1'b1) report_mismatch("resp_o.done", resp.done, 1'b1);
			if (resp.swap !== 1'b0) report_mismatch("resp_o.swap", resp.swap, 1'b0);
			if (resp.dflt !== exp_dflt) report_mismatch("resp_o.dflt", resp.dflt, exp_dflt);
		end else begin
			if (resp.done !== 1'b0) report_mismatch("resp_o.done", resp.done, 1'b0);
			if (resp.swap !== 1'b1) report_mismatch("resp_o.swap", resp.swap, 1'b1);
			if (resp.dflt !== 1'b0) report_mismatch("resp_o.dflt", resp.dflt, 1'b0);
			cycles = 1;
			while (resp.done !== 1'b1 && cycles < 6) begin
				@(negedge clock);
				cycles++;
			end
			if (resp.done !== 1'b1) report_failure("done never rose after an allocating miss");
			else if (cycles != 2) report_failure("done did not rise two cycles after the miss");
			exp_expired = 1'b0;
			way = -1;
			if (!m_full[set]) begin	// cold start walks the ways in order
				way = m_cold[set];
				m_cold[set]++;
				if (m_cold[set] == WAYS) m_full[set] = 1'b1;
			end else begin
				for (int w = WAYS - 1; w >= 0; w--) begin
					if (m_lease[w * SETS + set] == '0) way = w;
				end
				exp_expired = (way >= 0);
			end
			if (way < 0) begin
				// random way, only the set is known
				if (line_addr[SET_BW-1:0] !== SET_BW'(set))
					report_mismatch("addr_o set", line_addr[SET_BW-1:0], set);
				victim = int'(line_addr);
			end else begin
				victim = way * SETS + set;
				if (line_addr !== 4'(victim)) report_mismatch("addr_o", line_addr, victim);
			end
			if (resp.expired !== exp_expired)
				report_mismatch("resp_o.expired", resp.expired, exp_expired);
			if (resp.swap !== 1'b1) report_mismatch("resp_o.swap", resp.swap, 1'b1);
			@(negedge clock);
			if (resp.expired !== 1'b0) report_failure("expired stayed high for a second cycle");
			m_saved    = l;
			m_followup = 1'b1;
		end
		m_done = 1'b1;
	endtask

	task automatic cold_fill(input int set);
		int victim;
		for (int w = 0; w < WAYS; w++) begin
			do_miss(set, random_ref_addr(), victim);
			if (line_addr !== 4'(w * SETS + set))
				report_mismatch("addr_o cold start", line_addr, w * SETS + set);
			if (victim >= 0) do_hit(victim, random_ref_addr());	// follow-up fill
		end
	endtask

	// ------------------------------
	// directed tests
	task automatic test_config_port();
		logic [31:0] rdat;
		wb_write(ADR_DEFAULT, 32'h0000_beef);
		wb_read_check: begin
			wb_transfer(1'b0, ADR_DEFAULT, 32'h0, rdat);
			if (rdat !== {16'h0, m_default}) report_mismatch("wb_dat_o", rdat, {16'h0, m_default});
			wb_transfer(1'b0, ADR_DEFAULT + 6'd1, 32'h0, rdat);	// word 1 reads zero
			if (rdat !== 32'h0) report_mismatch("wb_dat_o", rdat, 32'h0);
		end
	endtask

	task automatic test_bypass_miss();
		int victim;
		wb_write(ADR_DEFAULT, 32'h0);
		do_miss(0, random_ref_addr(), victim);
		@(negedge clock);
		if (resp.dflt !== 1'b0) report_failure("dflt stayed high after the bypass miss");
		if (resp.done !== 1'b1 || resp.swap !== 1'b0)
			report_failure("a miss with a zero lease started a replacement");
	endtask

	task automatic test_cold_start();
		wb_write(ADR_DEFAULT, 32'd40);
		cold_fill(0);	// way 0 first also shows the bypass left set 0 empty
	endtask

	task automatic test_table_leases();
		int victim;
		int hits;
		cold_fill(2);
		write_table_entry(0, ADDR_A, 16'd3, 16'd12, 9'd511);
		write_table_entry(1, ADDR_B, 16'd12, 16'd6, 9'd0);
		do_hit(1 * SETS + 2, ADDR_A);	// lease0
		do_hit(2 * SETS + 2, ADDR_B);	// lease1
		hits = 0;
		while (m_lease[1 * SETS + 2] > 16'd1 && hits < 32) begin
			do_hit(FILL_LINE, random_ref_addr());
			hits++;
		end
		do_miss(2, random_ref_addr(), victim);
		if (line_addr !== 4'(1 * SETS + 2))
			report_mismatch("addr_o lease0 victim", line_addr, 1 * SETS + 2);
		do_hit(victim, random_ref_addr());
		hits = 0;
		while (m_lease[2 * SETS + 2] > 16'd1 && hits < 32) begin
			do_hit(FILL_LINE, random_ref_addr());
			hits++;
		end
		do_miss(2, random_ref_addr(), victim);
		if (line_addr !== 4'(2 * SETS + 2))
			report_mismatch("addr_o lease1 victim", line_addr, 2 * SETS + 2);
		do_hit(victim, random_ref_addr());
	endtask

	task automatic test_expired_victim();
		int victim;
		int hits;
		hits = 0;
		while (!set_run_down(0) && hits < 64) begin
			do_hit(FILL_LINE, random_ref_addr());
			hits++;
		end
		if (!set_run_down(0)) report_failure("leases of set 0 did not run down");
		do_miss(0, random_ref_addr(), victim);	// all expired, way 0 wins
		if (line_addr !== 4'd0) report_mismatch("addr_o expired victim", line_addr, 0);
		do_hit(victim, random_ref_addr());
		do_miss(0, random_ref_addr(), victim);	// way 0 renewed, way 1 next
		if (line_addr !== 4'(SETS)) report_mismatch("addr_o expired victim", line_addr, SETS);
		do_hit(victim, random_ref_addr());
	endtask

	task automatic test_random_victim();
		int victim;
		cold_fill(1);
		for (int i = 0; i < 3; i++) begin
			do_miss(1, random_ref_addr(), victim);
			if (victim % SETS != 1) report_mismatch("random victim set", victim % SETS, 1);
			do_hit(victim, random_ref_addr());
		end
	endtask

	// ------------------------------
	initial begin
		resetn      = 1'b0;
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		wb_we       = 1'b0;
		wb_adr      = '0;
		wb_dat      = '0;
		cache_addr  = '0;
		search_addr = '0;
		hit         = 1'b0;
		miss        = 1'b0;
		errors      = 0;
		rng_state   = 32'h76a3_f0c6;
		m_default   = '0;
		m_saved     = '0;
		m_followup  = 1'b0;
		m_done      = 1'b0;
		for (int i = 0; i < LINES; i++) m_lease[i] = '0;
		for (int s = 0; s < SETS; s++) begin
			m_cold[s] = 0;
			m_full[s] = 1'b0;
		end
		for (int i = 0; i < ENTRIES; i++) t_valid[i] = 1'b0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		resetn = 1'b1;
		if (resp !== '0) report_mismatch("resp_o", resp, 0);
		if (wb_ack !== 1'b0) report_mismatch("wb_ack_o", wb_ack, 0);
		test_config_port();
		test_bypass_miss();
		test_cold_start();
		test_table_leases();
		test_expired_victim();
		test_random_victim();
		$display("lease cache tests finished with %0d errors", errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// watchdog, generous margin over the longest test run
	initial begin
		#(20 * TEST_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- project.f
source/lease_pkg.sv
source/lfsr_9b.sv
source/lease_lookup_table.sv
source/lease_probability_select.sv
source/lease_config_wb_slave.sv
source/lease_policy_controller.sv
source/lease_cache_top.sv
testbench/lease_cache_asserts.sv
testbench/lease_cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the lease cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module lease_cache_tb \
	-f project.f -o lease_cache_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/lease_cache_sim > "$LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see $LOG"
	exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $LOG"
	exit 1
fi
